//--- common/vmem_defines.svh
// Sizing macros for the shared scratchpad, included by the package and every sizing RTL file
`ifndef VMEM_DEFINES_SVH
`define VMEM_DEFINES_SVH

// ----------------------------------------------------------------------
// Memory geometry
// ----------------------------------------------------------------------

// Word address width
`define VMEM_ADDR_W 6
// Data word width
`define VMEM_DATA_W 32
// Number of words, must fit the address width
`define VMEM_WORDS 64

// ----------------------------------------------------------------------
// Request lanes
// ----------------------------------------------------------------------

// Requesting lanes
`define VMEM_LANES 2
// Queue slots per lane
`define VMEM_QDEPTH 4

`endif

//--- common/vmem_pkg.sv
// Shared types for the scratchpad subsystem; modules import it inside their body
`include "vmem_defines.svh"

package vmem_pkg;

  // ----------------------------------------------------------------------
  // Width types
  // ----------------------------------------------------------------------

  // Word address into the scratch memory
  typedef logic [`VMEM_ADDR_W-1:0] addr_t;

  // One data word
  typedef logic [`VMEM_DATA_W-1:0] data_t;

  // Lane number, one bit for two lanes
  typedef logic [$clog2(`VMEM_LANES)-1:0] lane_t;

  // Queue occupancy, 0 up to and including the depth
  typedef logic [$clog2(`VMEM_QDEPTH+1)-1:0] qcnt_t;

  // ----------------------------------------------------------------------
  // Request and response
  // ----------------------------------------------------------------------

  // Pushed by a lane, executed by the memory
  typedef struct packed {
    // High for a write, low for a read
    logic  we;
    // Target word
    addr_t addr;
    // Write data, ignored on reads
    data_t data;
  } mem_req_t;

  // Read response, one-cycle pulse
  typedef struct packed {
    // Response present this cycle
    logic  valid;
    // Lane that issued the read
    lane_t lane;
    // Read data
    data_t data;
  } mem_rsp_t;

endpackage

//--- fifo/modn_counter.sv
// Wrapping modulo-N counter with clear and terminal count, used as a FIFO pointer
`timescale 1ns/1ps

module modn_counter #(
  parameter int N = 4,
  // Width also valid for N of 1
  localparam int W = (N > 1) ? $clog2(N) : 1
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         en_i,
  input  logic         clr_i,
  output logic [W-1:0] count_o,
  output logic         tc_o
);

  // Last value before the wrap
  localparam logic [W-1:0] LAST = W'(N - 1);

  logic [W-1:0] count_q;

  // ----------------------------------------------------------------------
  // Count register
  // ----------------------------------------------------------------------

  // Clear wins over enable
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (en_i) begin
      // Wrap at N-1
      if (count_q == LAST) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign count_o = count_q;
  // High for the whole cycle spent at N-1
  assign tc_o    = (count_q == LAST);

endmodule

//--- fifo/fifo_nohs.sv
// Request FIFO with externally driven push and pop, no flags; DEPTH of 0 passes data through
`timescale 1ns/1ps

module fifo_nohs #(
  parameter int DEPTH = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  logic               push_i,
  input  logic               pop_i,
  input  vmem_pkg::mem_req_t data_i,
  output vmem_pkg::mem_req_t data_o
);

  import vmem_pkg::*;

  generate
    if (DEPTH == 0) begin : gen_bypass
      // No storage, head is the input
      assign data_o = data_i;
    end else begin : gen_fifo
      // Pointer width, at least one bit
      localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

      // ------------------------------------------------------------------
      // Storage and pointers
      // ------------------------------------------------------------------

      // Next slot to read
      logic [PTR_W-1:0] head_q;
      // Next slot to write
      logic [PTR_W-1:0] tail_q;

      // Slot payloads
      mem_req_t         slot_data [DEPTH];
      // Slot occupied
      logic [DEPTH-1:0] slot_valid;

      // ------------------------------------------------------------------
      // Slot update
      // ------------------------------------------------------------------

      // Valid bits; push beats pop on the same slot
      always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
          slot_valid <= '0;
        end else if (flush_i) begin
          // Dropping the valid bits empties the queue
          slot_valid <= '0;
        end else begin
          for (int i = 0; i < DEPTH; i++) begin
            if (push_i && (tail_q == PTR_W'(i))) begin
              slot_valid[i] <= 1'b1;
            end else if (pop_i && (head_q == PTR_W'(i))) begin
              slot_valid[i] <= 1'b0;
            end
          end
        end
      end

      // Payload write at the tail
      always_ff @(posedge clk_i) begin
        for (int i = 0; i < DEPTH; i++) begin
          if (!flush_i && push_i && (tail_q == PTR_W'(i))) begin
            slot_data[i] <= data_i;
          end
        end
      end

      // ------------------------------------------------------------------
      // Head and tail pointers
      // ------------------------------------------------------------------

      modn_counter #(
        .N(DEPTH)
      ) u_head_cnt (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (pop_i),
        .clr_i  (flush_i),
        .count_o(head_q),
        .tc_o   ()
      );

      modn_counter #(
        .N(DEPTH)
      ) u_tail_cnt (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (push_i),
        .clr_i  (flush_i),
        .count_o(tail_q),
        .tc_o   ()
      );

      // ------------------------------------------------------------------
      // Output
      // ------------------------------------------------------------------

      // Head slot, zero while it holds nothing
      assign data_o = slot_valid[head_q] ? slot_data[head_q] : '0;
    end
  endgenerate

endmodule

//--- rtl/lane_req_queue.sv
// Per-lane request buffer: FIFO plus occupancy count that flags pending work to the arbiter
`timescale 1ns/1ps
`include "vmem_defines.svh"

module lane_req_queue (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  logic               push_i,
  input  logic               pop_i,
  input  vmem_pkg::mem_req_t req_i,
  output logic               pending_o,
  output vmem_pkg::mem_req_t head_o
);

  import vmem_pkg::*;

  // Count at a full queue
  localparam qcnt_t QFULL = qcnt_t'(`VMEM_QDEPTH);

  // Entries held
  qcnt_t occ_q;

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------

  // Push and pop together leave it unchanged
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      occ_q <= '0;
    end else if (flush_i) begin
      occ_q <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10: begin
          // Saturate, the FIFO overwrites its oldest entry
          if (occ_q != QFULL) begin
            occ_q <= occ_q + 1'b1;
          end
        end
        2'b01: begin
          if (occ_q != '0) begin
            occ_q <= occ_q - 1'b1;
          end
        end
        default: begin
          occ_q <= occ_q;
        end
      endcase
    end
  end

  // Work waiting for a grant
  assign pending_o = (occ_q != '0);

  // ----------------------------------------------------------------------
  // Request storage
  // ----------------------------------------------------------------------

  fifo_nohs #(
    .DEPTH(`VMEM_QDEPTH)
  ) u_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .push_i (push_i),
    .pop_i  (pop_i),
    .data_i (req_i),
    .data_o (head_o)
  );

endmodule

//--- rtl/rr_arbiter.sv
// Round-robin arbiter over the lanes' pending flags; combinational grant, registered last winner
`timescale 1ns/1ps
`include "vmem_defines.svh"

module rr_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`VMEM_LANES-1:0]  pending_i,
  output logic [`VMEM_LANES-1:0]  grant_o,
  output vmem_pkg::lane_t         grant_lane_o
);

  import vmem_pkg::*;

  localparam int LANES = `VMEM_LANES;

  // Lane that won most recently
  lane_t last_q;

  // ----------------------------------------------------------------------
  // Grant selection
  // ----------------------------------------------------------------------

  // Search starts one past the last winner
  always_comb begin : grant_sel
    int  idx;
    logic found;
    grant_o      = '0;
    grant_lane_o = '0;
    found        = 1'b0;
    for (int off = 1; off <= LANES; off++) begin
      idx = (int'(last_q) + off) % LANES;
      if (!found && pending_i[idx]) begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        grant_lane_o = lane_t'(idx);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Pointer
  // ----------------------------------------------------------------------

  // Reset to the last lane so lane 0 goes first
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q <= lane_t'(LANES - 1);
    end else if (|grant_o) begin
      last_q <= grant_lane_o;
    end
  end

endmodule

//--- rtl/scratch_mem.sv
// Single-port scratch memory; writes on go, reads return a lane-tagged response next cycle
`timescale 1ns/1ps
`include "vmem_defines.svh"

module scratch_mem (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               go_i,
  input  vmem_pkg::mem_req_t req_i,
  input  vmem_pkg::lane_t    lane_i,
  output vmem_pkg::mem_rsp_t rsp_o
);

  import vmem_pkg::*;

  // Word array
  data_t mem_q [`VMEM_WORDS];

  // Response pulse
  logic  rsp_valid_q;
  // Response payload
  lane_t rsp_lane_q;
  data_t rsp_data_q;

  // Unwritten words read back as zero
  initial begin
    foreach (mem_q[i]) begin
      mem_q[i] = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Memory access
  // ----------------------------------------------------------------------

  // Write port
  always_ff @(posedge clk_i) begin
    if (go_i && req_i.we) begin
      mem_q[req_i.addr] <= req_i.data;
    end
  end

  // Read data and lane tag, held between reads
  always_ff @(posedge clk_i) begin
    if (go_i && !req_i.we) begin
      rsp_lane_q <= lane_i;
      rsp_data_q <= mem_q[req_i.addr];
    end
  end

  // ----------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------

  // One cycle high per read, writes stay silent
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= go_i && !req_i.we;
    end
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.lane  = rsp_lane_q;
  assign rsp_o.data  = rsp_data_q;

endmodule

//--- rtl/vmem_share_top.sv
// Shared scratchpad top: two lane queues, round-robin arbiter and the scratch memory
`timescale 1ns/1ps
`include "vmem_defines.svh"

module vmem_share_top (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 flush_i,
  input  logic               [`VMEM_LANES-1:0] lane_push_i,
  input  vmem_pkg::mem_req_t [`VMEM_LANES-1:0] lane_req_i,
  output vmem_pkg::mem_rsp_t                   rsp_o
);

  import vmem_pkg::*;

  // Per-lane queue status
  logic     [`VMEM_LANES-1:0] lane_pending;
  mem_req_t [`VMEM_LANES-1:0] lane_head;

  // Grant doubles as the pop strobe
  logic     [`VMEM_LANES-1:0] lane_grant;
  lane_t                      grant_lane;

  // Request toward the memory
  mem_req_t                   mem_req;
  logic                       mem_go;

  // ----------------------------------------------------------------------
  // Lane queues
  // ----------------------------------------------------------------------

  lane_req_queue u_lane0 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (flush_i),
    .push_i   (lane_push_i[0]),
    .pop_i    (lane_grant[0]),
    .req_i    (lane_req_i[0]),
    .pending_o(lane_pending[0]),
    .head_o   (lane_head[0])
  );

  lane_req_queue u_lane1 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (flush_i),
    .push_i   (lane_push_i[1]),
    .pop_i    (lane_grant[1]),
    .req_i    (lane_req_i[1]),
    .pending_o(lane_pending[1]),
    .head_o   (lane_head[1])
  );

  // ----------------------------------------------------------------------
  // Arbitration and memory
  // ----------------------------------------------------------------------

  rr_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .pending_i   (lane_pending),
    .grant_o     (lane_grant),
    .grant_lane_o(grant_lane)
  );

  // Winning lane's head goes to memory
  assign mem_req = lane_head[grant_lane];
  assign mem_go  = |lane_grant;

  scratch_mem u_mem (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .go_i   (mem_go),
    .req_i  (mem_req),
    .lane_i (grant_lane),
    .rsp_o  (rsp_o)
  );

endmodule

//--- testbench/vmem_share_props.sv
// Protocol checks bound into the scratchpad top, reaching into both lane queues
`timescale 1ns/1ps
`include "vmem_defines.svh"

module vmem_share_props (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   flush_i,
  input logic [`VMEM_LANES-1:0] push_i,
  input logic [`VMEM_LANES-1:0] pending_i,
  input logic [`VMEM_LANES-1:0] grant_i,
  input vmem_pkg::qcnt_t        occ0_i,
  input vmem_pkg::qcnt_t        occ1_i,
  input logic                   go_i,
  input logic                   go_we_i,
  input logic                   rsp_valid_i
);

  import vmem_pkg::*;

  localparam qcnt_t QFULL = qcnt_t'(`VMEM_QDEPTH);

  // Failed checks, summed into the testbench's closing line
  int unsigned fail_cnt = 0;

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_i)) else begin
    fail_cnt++;
    $error("more than one lane granted");
  end

  // Both pending twice in a row means the other lane wins
  a_grant_alt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (&pending_i) |=> (!(&pending_i) || (grant_i != $past(grant_i)))) else begin
    fail_cnt++;
    $error("grant did not alternate with both lanes pending");
  end

  // ----------------------------------------------------------------------
  // Queue depth and responses
  // ----------------------------------------------------------------------

  a_no_ovf0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (push_i[0] && !grant_i[0] && !flush_i) |-> (occ0_i != QFULL)) else begin
    fail_cnt++;
    $error("lane 0 pushed while full");
  end

  a_no_ovf1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (push_i[1] && !grant_i[1] && !flush_i) |-> (occ1_i != QFULL)) else begin
    fail_cnt++;
    $error("lane 1 pushed while full");
  end

  a_rsp_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> $past(go_i && !go_we_i)) else begin
    fail_cnt++;
    $error("response without a read grant");
  end

endmodule

bind vmem_share_top vmem_share_props u_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .flush_i    (flush_i),
  .push_i     (lane_push_i),
  .pending_i  (lane_pending),
  .grant_i    (lane_grant),
  .occ0_i     (u_lane0.occ_q),
  .occ1_i     (u_lane1.occ_q),
  .go_i       (mem_go),
  .go_we_i    (mem_req.we),
  .rsp_valid_i(rsp_o.valid)
);

//--- testbench/tb_vmem_share.sv
// Simulation top that checks the scratchpad's rsp_o against a cycle model of queues and memory
`timescale 1ns/1ps
`include "vmem_defines.svh"

module tb_vmem_share;

  import vmem_pkg::*;

  // Planned pushes per phase
  localparam int N_SOLO  = 40;
  localparam int N_DUAL  = 24;
  localparam int N_FLUSH = 12;
  // Run limit taken from the total push count
  localparam int N_TOTAL = 1 + N_SOLO + 2 * N_DUAL + 2 * N_FLUSH + 16;
  localparam int LIMIT   = 4 * N_TOTAL + 50;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       flush_i;
  logic     [`VMEM_LANES-1:0] lane_push_i;
  mem_req_t [`VMEM_LANES-1:0] lane_req_i;
  mem_rsp_t                   rsp_o;

  // Model of the lane queues, the memory and the RR pointer
  mem_req_t model_q [`VMEM_LANES][$];
  data_t    model_mem [`VMEM_WORDS];
  lane_t    model_last;
  // What rsp_o must show after the latest edge
  logic     exp_valid;
  lane_t    exp_lane;
  data_t    exp_data;

  int cycles = 0;
  int mismatches = 0;
  int rsp_errs = 0;

  vmem_share_top UUT (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .lane_push_i(lane_push_i),
    .lane_req_i (lane_req_i),
    .rsp_o      (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Model and stimulus helpers
  // ----------------------------------------------------------------------

  function automatic mem_req_t mk(input int we, input int addr, input data_t data);
    mem_req_t r;
    r.we   = (we != 0);
    r.addr = addr_t'(addr);
    r.data = data;
    return r;
  endfunction

  // Applies one edge to the model using the inputs sampled on it
  task automatic model_edge();
    mem_req_t req;
    lane_t    win;
    logic     grant;
    // Other lane has priority over the last winner
    win   = ~model_last;
    grant = 1'b1;
    if (model_q[win].size() == 0) begin
      win   = model_last;
      grant = (model_q[win].size() != 0);
    end
    exp_valid = 1'b0;
    if (grant) begin
      req        = model_q[win].pop_front();
      model_last = win;
      if (req.we) begin
        model_mem[req.addr] = req.data;
      end else begin
        exp_valid = 1'b1;
        exp_lane  = win;
        exp_data  = model_mem[req.addr];
      end
    end
    // Flush drops queued work and pushes on the same edge
    if (flush_i) begin
      model_q[0].delete();
      model_q[1].delete();
    end else begin
      for (int l = 0; l < `VMEM_LANES; l++) begin
        if (lane_push_i[l]) begin
          model_q[l].push_back(lane_req_i[l]);
        end
      end
    end
  endtask

  // Advances one edge and drives the next cycle's inputs
  task automatic step(input logic [`VMEM_LANES-1:0] push, input mem_req_t r0,
                      input mem_req_t r1, input logic flush);
    logic [`VMEM_LANES-1:0] room;
    @(posedge clk_i);
    model_edge();
    // Push only where the queue has room
    for (int l = 0; l < `VMEM_LANES; l++) begin
      room[l] = (model_q[l].size() < `VMEM_QDEPTH);
    end
    lane_push_i   <= push & room;
    lane_req_i[0] <= r0;
    lane_req_i[1] <= r1;
    flush_i       <= flush;
  endtask

  // Idle until both queues are empty and the last read has answered
  task automatic drain();
    while ((model_q[0].size() + model_q[1].size()) != 0) begin
      step('0, '0, '0, 1'b0);
    end
    // Room for a push still in flight and its response
    repeat (2) step('0, '0, '0, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Response checks on the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      assert (rsp_o.valid == exp_valid) else begin
        rsp_errs++;
        $display("%s read response in cycle %0d", exp_valid ? "Missing" : "Unexpected", cycles);
      end
      if (exp_valid && rsp_o.valid) begin
        assert (rsp_o.lane == exp_lane) else begin
          mismatches++;
          $display("MISMATCH rsp_o.lane expected %h got %h", exp_lane, rsp_o.lane);
        end
        assert (rsp_o.data == exp_data) else begin
          mismatches++;
          $display("MISMATCH rsp_o.data expected %h got %h", exp_data, rsp_o.data);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(80));
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    lane_push_i = '0;
    lane_req_i  = '0;
    model_last  = lane_t'(`VMEM_LANES - 1);
    exp_valid   = 1'b0;
    exp_lane    = '0;
    exp_data    = '0;
    foreach (model_mem[a]) begin
      model_mem[a] = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Quiet cycles after reset
    repeat (3) step('0, '0, '0, 1'b0);
    // One read on lane 1 of an unwritten word
    step(2'b10, '0, mk(0, 3, '0), 1'b0);
    drain();

    // Random reads and writes from lane 0 over a few hot words
    for (int i = 0; i < N_SOLO; i++) begin
      step(($urandom_range(3, 0) != 0) ? 2'b01 : 2'b00,
           mk(int'($urandom_range(1, 0)), int'($urandom_range(7, 0)), $urandom()), '0, 1'b0);
    end
    drain();

    // Back-to-back reads from both lanes so that grants alternate
    for (int i = 0; i < N_DUAL; i++) begin
      step(2'b11, mk(0, int'($urandom_range(15, 0)), '0),
           mk(0, int'($urandom_range(15, 0)), '0), 1'b0);
    end
    drain();

    // Fill both queues before the flush
    for (int i = 0; i < N_FLUSH; i++) begin
      step(2'b11, mk(1, 16 + i % 8, $urandom()), mk(i % 2, 24 + i % 8, $urandom()), 1'b0);
    end
    step('0, '0, '0, 1'b1);
    // Read back every word the flushed traffic could touch
    for (int a = 16; a < 32; a++) begin
      step(2'b01, mk(0, a, '0), '0, 1'b0);
    end
    drain();

    $display("Errors: %0d value mismatches, %0d response errors, %0d assertion failures",
             mismatches, rsp_errs, UUT.u_props.fail_cnt);
    if (mismatches + rsp_errs + int'(UUT.u_props.fail_cnt) == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+common
common/vmem_pkg.sv
fifo/modn_counter.sv
fifo/fifo_nohs.sv
rtl/lane_req_queue.sv
rtl/rr_arbiter.sv
rtl/scratch_mem.sv
rtl/vmem_share_top.sv
testbench/vmem_share_props.sv
testbench/tb_vmem_share.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_vmem_share
FILELIST  := build.f
OBJDIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the run prints the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJDIR)
